//--- design/stk_pkg.sv
// Stack unit shared definitions
package stk_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 0 of a push or pull opcode picks the user stack
    // LBSR is odd too, but the sequencer keeps it on S
    typedef enum logic [7:0] {
        OP_LBSR = 8'h17,
        OP_PSHS = 8'h34,
        OP_PSHU = 8'h35,
        OP_PULS = 8'h36,
        OP_PULU = 8'h37,
        OP_RTI  = 8'h3b
    } op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register indices
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Each index equals the postbyte bit of the same register
    // Indices 4 and up are the 16-bit registers
    typedef enum logic [2:0] {
        R_CC = 3'd0,
        R_A  = 3'd1,
        R_B  = 3'd2,
        R_DP = 3'd3,
        R_X  = 3'd4,
        R_Y  = 3'd5,
        R_SU = 3'd6,
        R_PC = 3'd7
    } reg_e;

    // Entire-state flag, set when the whole frame sits on the stack
    localparam int CC_E = 7;

    // Forced postbytes for the fixed-frame instructions
    localparam logic [7:0] PB_ALL   = 8'hff;
    localparam logic [7:0] PB_PC    = 8'h80;
    localparam logic [7:0] PB_PCCC  = 8'h81;
    localparam logic [7:0] PB_CC    = 8'h01;
    // Everything except CC, which the RTI first pass already pulled
    localparam logic [7:0] PB_RTI_E = 8'hfe;

endpackage

//--- design/stk_ram.sv
// Byte-wide stack memory
`timescale 1ns/1ns

module stk_ram #(
    parameter int STACK_AW = 8
) (
    input  logic                clk,
    input  logic                we,
    input  logic [STACK_AW-1:0] addr,
    input  logic [7:0]          din,
    output logic [7:0]          dout
);

    localparam int DEPTH = 2 ** STACK_AW;

    // Addresses wrap naturally since the index is exactly STACK_AW bits
    logic [7:0] mem [DEPTH];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // Read is combinational so a pull step sees the byte in the same cycle
    assign dout = mem[addr];

endmodule

//--- design/stk_reg_pick.sv
// Register priority picker
`timescale 1ns/1ns

module stk_reg_pick (
    input  logic [7:0]       psh_sel,
    input  logic             pul_en,
    output logic [7:0]       psh_bit,
    output stk_pkg::reg_e    reg_idx,
    output logic             pul_step
);

    import stk_pkg::*;

    // A pull step needs a register still waiting in the mask
    assign pul_step = pul_en & (|psh_sel);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Priority encoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Pushes go from PC down to CC so that CC ends at the lowest address
    // Pulls undo that order and go from CC up to PC
    always_comb begin
        logic [2:0] pick;
        logic       found;

        pick  = 3'd0;
        found = 1'b0;
        if (pul_en) begin
            // Scan downward so that the last hit is the lowest bit
            for (int i = 7; i >= 0; i--) begin
                if (psh_sel[i]) begin
                    pick  = 3'(i);
                    found = 1'b1;
                end
            end
        end else begin
            // Scan upward so that the last hit is the highest bit
            for (int i = 0; i < 8; i++) begin
                if (psh_sel[i]) begin
                    pick  = 3'(i);
                    found = 1'b1;
                end
            end
        end

        // Empty selection gives an empty mask
        psh_bit = found ? (8'h01 << pick) : 8'h00;
        reg_idx = reg_e'(pick);
    end

endmodule

//--- design/stk_pshpul.sv
// Stack push/pull sequencer
`timescale 1ns/1ns

module stk_pshpul (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,

    input  stk_pkg::op_e     op,
    input  logic [7:0]       postdata,
    input  logic [7:0]       cc,
    input  logic             psh_all,
    input  logic             rti_cc,
    input  logic             rti_other,

    input  logic             pul_go,
    input  logic             psh_go,
    input  logic             psh_pc,
    input  logic             psh_cc,
    input  logic [7:0]       psh_bit,
    output logic             hihalf,
    output logic             pul_en,
    output logic             psh_dec,

    output logic [7:0]       psh_sel,
    output logic             busy,
    output logic             us_sel
);

    import stk_pkg::*;

    logic [7:0] postbyte;
    logic       forced;
    logic       dec_en;
    logic       wide;

    // The unit is busy for as long as any selected register is left
    assign busy    = |psh_sel;
    assign psh_dec = dec_en & busy;

    // Registers PC, the other stack, Y and X take two byte steps
    assign wide = |psh_bit[7:4];

    // Any forcing input overrides the postbyte from the instruction stream
    assign forced = rti_cc | psh_pc | psh_cc | rti_other | psh_all;

    // Forced selections in priority order
    always_comb begin
        if (rti_cc) begin
            postbyte = PB_CC;
        end else if (psh_pc) begin
            postbyte = PB_PC;
        end else if (psh_cc) begin
            postbyte = PB_PCCC;
        end else if (rti_other) begin
            // With E clear only the return address was stacked
            postbyte = cc[CC_E] ? PB_RTI_E : PB_PC;
        end else if (psh_all) begin
            postbyte = PB_ALL;
        end else begin
            postbyte = postdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command capture and byte stepping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psh_sel <= 8'h00;
            hihalf  <= 1'b0;
            us_sel  <= 1'b0;
            pul_en  <= 1'b0;
            dec_en  <= 1'b0;
        end else if (cen) begin
            if (!busy) begin
                // Direction flags drop once the previous command has drained
                pul_en <= 1'b0;
                dec_en <= 1'b0;
                if (psh_go || pul_go) begin
                    psh_sel <= postbyte;
                    hihalf  <= 1'b0;
                    // Only plain PSHU and PULU work on the user stack
                    us_sel  <= op[0] && (op != OP_LBSR) && !forced;
                    pul_en  <= pul_go;
                    dec_en  <= psh_go;
                end
            end else begin
                if (wide && !hihalf) begin
                    // First half of a 16-bit register, stay on the same bit
                    hihalf <= 1'b1;
                end else begin
                    hihalf  <= 1'b0;
                    psh_sel <= psh_sel & ~psh_bit;
                end
            end
        end
    end

endmodule

//--- design/stk_regs.sv
// Register set and stack pointers
`timescale 1ns/1ns

module stk_regs #(
    parameter int STACK_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,

    input  logic                psh_dec,
    input  logic                pul_step,
    input  logic                hihalf,
    input  logic                us_sel,
    input  stk_pkg::reg_e       reg_idx,

    input  logic [7:0]          ram_dout,
    output logic [STACK_AW-1:0] ram_addr,
    output logic [7:0]          ram_din,
    output logic                ram_we,

    output logic [7:0]          cc,

    input  logic                ld_en,
    input  stk_pkg::reg_e       ld_idx,
    input  logic                ld_us,
    input  logic [15:0]         ld_data,
    input  stk_pkg::reg_e       rd_idx,
    output logic [15:0]         rd_data,

    output logic [15:0]         sp_s,
    output logic [15:0]         sp_u
);

    import stk_pkg::*;

    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  dp;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] pc;

    logic [15:0] sp_act;
    logic [15:0] sp_other;
    logic [15:0] sp_addr;
    logic [15:0] sel_val;
    logic        push_now;
    logic        pull_now;
    logic        ld_ok;

    // Pulled byte goes to the high half on the first step of a 16-bit register
    function automatic logic [15:0] put_byte(input logic [15:0] old, input logic [7:0] data,
                                             input logic low);
        put_byte = low ? {old[15:8], data} : {data, old[7:0]};
    endfunction

    assign push_now = psh_dec & cen;
    assign pull_now = pul_step & cen;
    // The test port stays out of the way of a running transfer
    assign ld_ok    = ld_en & ~(psh_dec | pul_step);

    assign sp_act   = us_sel ? sp_u : sp_s;
    assign sp_other = us_sel ? sp_s : sp_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stack address and write data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Pushes pre-decrement, pulls read at the pointer and post-increment
    assign sp_addr  = psh_dec ? sp_act - 16'd1 : sp_act;
    assign ram_addr = sp_addr[STACK_AW-1:0];
    assign ram_we   = push_now;
    // Low byte leaves first, so the high byte ends up at the lower address
    assign ram_din  = hihalf ? sel_val[15:8] : sel_val[7:0];

    always_comb begin
        case (reg_idx)
            R_CC:    sel_val = {8'h00, cc};
            R_A:     sel_val = {8'h00, a};
            R_B:     sel_val = {8'h00, b};
            R_DP:    sel_val = {8'h00, dp};
            R_X:     sel_val = x;
            R_Y:     sel_val = y;
            R_SU:    sel_val = sp_other;
            default: sel_val = pc;
        endcase
    end

    // Test port read, 8-bit registers come back zero-extended
    always_comb begin
        case (rd_idx)
            R_CC:    rd_data = {8'h00, cc};
            R_A:     rd_data = {8'h00, a};
            R_B:     rd_data = {8'h00, b};
            R_DP:    rd_data = {8'h00, dp};
            R_X:     rd_data = x;
            R_Y:     rd_data = y;
            R_SU:    rd_data = ld_us ? sp_u : sp_s;
            default: rd_data = pc;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cc   <= 8'h00;
            a    <= 8'h00;
            b    <= 8'h00;
            dp   <= 8'h00;
            x    <= 16'h0000;
            y    <= 16'h0000;
            pc   <= 16'h0000;
            sp_s <= 16'h0000;
            sp_u <= 16'h0000;
        end else if (ld_ok) begin
            // Direct load, independent of the clock enable
            case (ld_idx)
                R_CC:    cc <= ld_data[7:0];
                R_A:     a  <= ld_data[7:0];
                R_B:     b  <= ld_data[7:0];
                R_DP:    dp <= ld_data[7:0];
                R_X:     x  <= ld_data;
                R_Y:     y  <= ld_data;
                R_SU: begin
                    if (ld_us) sp_u <= ld_data;
                    else       sp_s <= ld_data;
                end
                default: pc <= ld_data;
            endcase
        end else if (pull_now) begin
            case (reg_idx)
                R_CC:    cc <= ram_dout;
                R_A:     a  <= ram_dout;
                R_B:     b  <= ram_dout;
                R_DP:    dp <= ram_dout;
                R_X:     x  <= put_byte(x, ram_dout, hihalf);
                R_Y:     y  <= put_byte(y, ram_dout, hihalf);
                R_SU: begin
                    // The other pointer, never the one doing the pull
                    if (us_sel) sp_s <= put_byte(sp_s, ram_dout, hihalf);
                    else        sp_u <= put_byte(sp_u, ram_dout, hihalf);
                end
                default: pc <= put_byte(pc, ram_dout, hihalf);
            endcase
            if (us_sel) sp_u <= sp_u + 16'd1;
            else        sp_s <= sp_s + 16'd1;
        end else if (push_now) begin
            if (us_sel) sp_u <= sp_u - 16'd1;
            else        sp_s <= sp_s - 16'd1;
        end
    end

endmodule

//--- design/stk_unit.sv
// Stack transfer unit top level
`timescale 1ns/1ns

module stk_unit #(
    parameter int STACK_AW = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,

    // Command inputs
    input  stk_pkg::op_e     op,
    input  logic [7:0]       postdata,
    input  logic             psh_go,
    input  logic             pul_go,
    input  logic             psh_all,
    input  logic             psh_pc,
    input  logic             psh_cc,
    input  logic             rti_cc,
    input  logic             rti_other,

    // Test port
    input  logic             ld_en,
    input  stk_pkg::reg_e    ld_idx,
    input  logic             ld_us,
    input  logic [15:0]      ld_data,
    input  stk_pkg::reg_e    rd_idx,
    output logic [15:0]      rd_data,

    // Status
    output logic             busy,
    output logic [15:0]      sp_s,
    output logic [15:0]      sp_u
);

    import stk_pkg::*;

    // Sequencer and picker handshake
    logic [7:0]          psh_sel;
    logic [7:0]          psh_bit;
    logic                pul_en;
    logic                pul_step;
    reg_e                reg_idx;

    // Sequencer to register set
    logic                hihalf;
    logic                psh_dec;
    logic                us_sel;
    logic [7:0]          cc;

    // Register set to stack memory
    logic [STACK_AW-1:0] ram_addr;
    logic [7:0]          ram_din;
    logic [7:0]          ram_dout;
    logic                ram_we;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Block instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stk_pshpul u_pshpul (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .postdata  (postdata),
        .cc        (cc),
        .psh_all   (psh_all),
        .rti_cc    (rti_cc),
        .rti_other (rti_other),
        .pul_go    (pul_go),
        .psh_go    (psh_go),
        .psh_pc    (psh_pc),
        .psh_cc    (psh_cc),
        .psh_bit   (psh_bit),
        .hihalf    (hihalf),
        .pul_en    (pul_en),
        .psh_dec   (psh_dec),
        .psh_sel   (psh_sel),
        .busy      (busy),
        .us_sel    (us_sel)
    );

    stk_reg_pick u_pick (
        .psh_sel  (psh_sel),
        .pul_en   (pul_en),
        .psh_bit  (psh_bit),
        .reg_idx  (reg_idx),
        .pul_step (pul_step)
    );

    stk_regs #(
        .STACK_AW (STACK_AW)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .psh_dec  (psh_dec),
        .pul_step (pul_step),
        .hihalf   (hihalf),
        .us_sel   (us_sel),
        .reg_idx  (reg_idx),
        .ram_dout (ram_dout),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_we   (ram_we),
        .cc       (cc),
        .ld_en    (ld_en),
        .ld_idx   (ld_idx),
        .ld_us    (ld_us),
        .ld_data  (ld_data),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .sp_s     (sp_s),
        .sp_u     (sp_u)
    );

    stk_ram #(
        .STACK_AW (STACK_AW)
    ) u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

endmodule

//--- dv/stk_ref.svh
// Stack unit reference model
`ifndef STK_REF_SVH
`define STK_REF_SVH

// The forcing vector frc is {psh_all, rti_other, psh_cc, psh_pc, rti_cc}
// Earlier forcing inputs win over later ones
function automatic logic [7:0] ref_postbyte(input logic [4:0] frc, input logic [7:0] cc_val,
                                            input logic [7:0] plain);
    if (frc[0])
        return 8'h01;
    else if (frc[1])
        return 8'h80;
    else if (frc[2])
        return 8'h81;
    else if (frc[3])
        // E set means the whole frame was stacked
        return cc_val[7] ? 8'hfe : 8'h80;
    else if (frc[4])
        return 8'hff;
    else
        return plain;
endfunction

// Bits 7 to 4 name 16-bit registers and cost two bytes each
function automatic int ref_bytes(input logic [7:0] pb);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
        if (pb[i])
            n = n + ((i >= 4) ? 2 : 1);
    end
    return n;
endfunction

// Returns 1 when the user stack is used
// The S opcodes and LBSR stay on S, the U push and pull move to U
function automatic logic ref_stack(input op_e op_v, input logic forced);
    logic user;
    case (op_v)
        OP_PSHS, OP_PULS, OP_LBSR: user = 1'b0;
        OP_PSHU, OP_PULU:          user = 1'b1;
        default:                   user = op_v[0];
    endcase
    // Every forced frame goes to the system stack
    if (forced)
        user = 1'b0;
    return user;
endfunction

// Pointer after a command that moved n bytes
function automatic logic [15:0] ref_sp_after(input logic [15:0] sp, input int n,
                                             input logic push);
    return push ? sp - 16'(n) : sp + 16'(n);
endfunction

`endif

//--- dv/stk_tb.sv
// Stack unit testbench
`timescale 1ns/1ns

module stk_tb;

    import stk_pkg::*;

    `include "stk_ref.svh"

    localparam int CLK_PERIOD = 8;
    localparam int N_ROUNDS   = 6;
    localparam int N_GATE     = 2;
    // Reset check, plain pairs, six forced pairs, the LBSR pair and the gated pairs
    localparam int N_CMDS     = 1 + 4 * N_ROUNDS + 12 + 2 + 2 * N_GATE;

    logic        clk;
    logic        rst;
    logic        cen;
    op_e         op;
    logic [7:0]  postdata;
    logic        psh_go;
    logic        pul_go;
    logic        psh_all;
    logic        psh_pc;
    logic        psh_cc;
    logic        rti_cc;
    logic        rti_other;
    logic        ld_en;
    reg_e        ld_idx;
    logic        ld_us;
    logic [15:0] ld_data;
    reg_e        rd_idx;
    logic [15:0] rd_data;
    logic        busy;
    logic [15:0] sp_s;
    logic [15:0] sp_u;

    // Expected state, and the copy taken when a frame is pushed
    logic [15:0] exp_val [8];
    logic [15:0] exp_s;
    logic [15:0] exp_u;
    logic [15:0] saved_val [8];
    logic [15:0] saved_s;
    logic [15:0] saved_u;
    int          exp_n;
    integer      seed     = 32'ha9a7;
    integer      cen_seed = 32'ha9a7;
    logic        cen_rand = 1'b0;
    event        cmd_issued;
    event        check_done;

    stk_unit #(
        .STACK_AW (8)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op        (op),
        .postdata  (postdata),
        .psh_go    (psh_go),
        .pul_go    (pul_go),
        .psh_all   (psh_all),
        .psh_pc    (psh_pc),
        .psh_cc    (psh_cc),
        .rti_cc    (rti_cc),
        .rti_other (rti_other),
        .ld_en     (ld_en),
        .ld_idx    (ld_idx),
        .ld_us     (ld_us),
        .ld_data   (ld_data),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .busy      (busy),
        .sp_s      (sp_s),
        .sp_u      (sp_u)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Clock enable stays high except in the gated runs
    initial begin : cen_drive
        integer r;
        forever begin
            @(negedge clk);
            r   = $random(cen_seed);
            cen = cen_rand ? r[0] : 1'b1;
        end
    end

    initial begin : watchdog
        #(N_CMDS * 40 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", N_CMDS * 40);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic read_reg(input reg_e idx, input logic us, output logic [15:0] val);
        @(negedge clk);
        rd_idx = idx;
        ld_us  = us;
        #1;
        val = rd_data;
    endtask

    initial begin : compare
        int          count;
        logic        seen;
        logic [15:0] val;
        forever begin
            @(cmd_issued);
            count = 0;
            seen  = 1'b0;
            if (exp_n == 0) begin
                repeat (3) begin
                    @(negedge clk);
                    #1;
                    check_equal(busy, 1'b0, "busy with nothing selected");
                end
            end else begin
                // Each sample just after a falling edge describes the coming rising edge
                while (!seen || busy) begin
                    @(negedge clk);
                    #1;
                    if (busy)
                        seen = 1'b1;
                    if (busy && cen)
                        count++;
                end
                check_equal(16'(count), 16'(exp_n), "enabled busy cycles");
            end
            for (int i = 0; i < 8; i++) begin
                if (i != 6) begin
                    read_reg(reg_e'(i), 1'b0, val);
                    check_equal(val, exp_val[i], $sformatf("register index %0d", i));
                end
            end
            read_reg(R_SU, 1'b0, val);
            check_equal(val, exp_s, "S through the test port");
            read_reg(R_SU, 1'b1, val);
            check_equal(val, exp_u, "U through the test port");
            check_equal(sp_s, exp_s, "sp_s output");
            check_equal(sp_u, exp_u, "sp_u output");
            -> check_done;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Load lands at the next rising edge, ld_en stays up for back to back loads
    task automatic load_reg(input reg_e idx, input logic us, input logic [15:0] data);
        @(negedge clk);
        ld_en   = 1'b1;
        ld_idx  = idx;
        ld_us   = us;
        ld_data = data;
        if (idx == R_SU) begin
            if (us)
                exp_u = data;
            else
                exp_s = data;
        end else if (idx < R_X) begin
            exp_val[idx] = {8'h00, data[7:0]};
        end else begin
            exp_val[idx] = data;
        end
    endtask

    task automatic end_load;
        @(negedge clk);
        ld_en = 1'b0;
    endtask

    task automatic load_regs(input logic keep_s, input logic keep_u, input logic keep_e);
        logic [15:0] data;
        for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            // A kept E bit keeps the RTI postbyte the same for the pull
            if (i == 0 && keep_e)
                data[7] = exp_val[R_CC][7];
            if (i != 6)
                load_reg(reg_e'(i), 1'b0, data);
        end
        data = $random(seed);
        if (!keep_s)
            load_reg(R_SU, 1'b0, data);
        data = $random(seed);
        if (!keep_u)
            load_reg(R_SU, 1'b1, data);
        end_load();
    endtask

    task automatic run_cmd(input logic push, input op_e op_v, input logic [4:0] frc,
                           input logic [7:0] plain, input logic extra);
        logic [7:0] pb;
        logic       use_u;
        int         n;
        pb    = ref_postbyte(frc, exp_val[R_CC][7:0], plain);
        n     = ref_bytes(pb);
        use_u = ref_stack(op_v, |frc);
        if (push) begin
            for (int i = 0; i < 8; i++)
                saved_val[i] = exp_val[i];
            saved_s = exp_s;
            saved_u = exp_u;
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (pb[i] && i != 6)
                    exp_val[i] = saved_val[i];
            end
            // Bit 6 brings back the pointer that was not doing the pull
            if (pb[6]) begin
                if (use_u)
                    exp_s = saved_s;
                else
                    exp_u = saved_u;
            end
        end
        if (use_u)
            exp_u = ref_sp_after(exp_u, n, push);
        else
            exp_s = ref_sp_after(exp_s, n, push);
        exp_n = n;

        @(negedge clk);
        op        = op_v;
        postdata  = plain;
        {psh_all, rti_other, psh_cc, psh_pc, rti_cc} = frc;
        psh_go    = push;
        pul_go    = !push;
        -> cmd_issued;
        // Hold the strobe until a rising edge with cen high takes it
        #1;
        while (!(cen && !busy)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        psh_go = 1'b0;
        pul_go = 1'b0;
        {psh_all, rti_other, psh_cc, psh_pc, rti_cc} = 5'b00000;
        if (extra) begin
            // Opposite strobe with another postbyte while the unit is busy
            @(negedge clk);
            if (busy) begin
                psh_go   = !push;
                pul_go   = push;
                postdata = ~plain;
            end
            @(negedge clk);
            psh_go = 1'b0;
            pul_go = 1'b0;
        end
        @(check_done);
    endtask

    task automatic run_pair(input op_e psh_op, input op_e pul_op, input logic [4:0] frc,
                            input logic [7:0] plain, input logic extra);
        logic use_u;
        use_u = ref_stack(psh_op, |frc);
        run_cmd(1'b1, psh_op, frc, plain, extra);
        // Fresh values everywhere except the pointer holding the frame
        load_regs(!use_u, use_u, 1'b1);
        run_cmd(1'b0, pul_op, frc, plain, extra);
    endtask

    initial begin : stimulus
        logic [7:0] pb;
        logic [4:0] frc;
        rst       = 1'b1;
        cen       = 1'b1;
        op        = OP_PSHS;
        postdata  = 8'h00;
        psh_go    = 1'b0;
        pul_go    = 1'b0;
        psh_all   = 1'b0;
        psh_pc    = 1'b0;
        psh_cc    = 1'b0;
        rti_cc    = 1'b0;
        rti_other = 1'b0;
        ld_en     = 1'b0;
        ld_idx    = R_CC;
        ld_us     = 1'b0;
        ld_data   = 16'h0000;
        rd_idx    = R_CC;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state
        for (int i = 0; i < 8; i++)
            exp_val[i] = 16'h0000;
        exp_s = 16'h0000;
        exp_u = 16'h0000;
        exp_n = 0;
        -> cmd_issued;
        @(check_done);

        // Plain pushes and their matching pulls on both stacks
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int st = 0; st < 2; st++) begin
                load_regs(1'b0, 1'b0, 1'b0);
                pb = $random(seed);
                run_pair(st ? OP_PSHU : OP_PSHS, st ? OP_PULU : OP_PULS, 5'b00000, pb, 1'b0);
            end
        end

        // Forced selections, given a U opcode that they must override
        for (int f = 0; f < 6; f++) begin
            case (f)
                0:       frc = 5'b00001;
                1:       frc = 5'b00010;
                2:       frc = 5'b00100;
                3:       frc = 5'b10000;
                default: frc = 5'b01000;
            endcase
            load_regs(1'b0, 1'b0, 1'b0);
            if (f >= 4) begin
                load_reg(R_CC, 1'b0, {8'h00, (f == 5), exp_val[R_CC][6:0]});
                end_load();
            end
            pb = $random(seed);
            run_pair(OP_PSHU, OP_PULU, frc, pb, 1'b0);
        end

        // LBSR is odd but stays on S
        load_regs(1'b0, 1'b0, 1'b0);
        pb = $random(seed);
        run_pair(OP_LBSR, OP_LBSR, 5'b00000, pb, 1'b0);

        // Random clock enable and a stray strobe during each command
        cen_rand = 1'b1;
        for (int g = 0; g < N_GATE; g++) begin
            load_regs(1'b0, 1'b0, 1'b0);
            pb = $random(seed);
            pb = pb | 8'h80;
            run_pair(g[0] ? OP_PSHU : OP_PSHS, g[0] ? OP_PULU : OP_PULS, 5'b00000, pb, 1'b1);
        end
        cen_rand = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+dv
design/stk_pkg.sv
design/stk_ram.sv
design/stk_reg_pick.sv
design/stk_pshpul.sv
design/stk_regs.sv
design/stk_unit.sv
dv/stk_tb.sv

//--- Bender.yml
package:
  name: stk_unit

sources:
  - files:
      - design/stk_pkg.sv
      - design/stk_ram.sv
      - design/stk_reg_pick.sv
      - design/stk_pshpul.sv
      - design/stk_regs.sv
      - design/stk_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/stk_tb.sv
